//--- build.f
+incdir+include
src/pattern_pkg.sv
src/monitor_pkg.sv
src/chk_result_if.sv
src/prbs_lane_bank.sv
src/prbs_lane_checker.sv
src/link_stat_unit.sv
src/prbs_link_emu.sv
testbench/link_scoreboard.sv
testbench/tb_prbs_link_emu.sv

//--- testbench/tb_prbs_link_emu.sv
`timescale 1ns/1ps
`include "prbs_defines.svh"

module tb_prbs_link_emu;
    import pattern_pkg::*;

    localparam int NTI           = `PRBS_NTI;
    localparam int CLK_HALF      = 4;
    localparam int PATTERN_WORDS = 200;
    localparam int LOCK_WORDS    = 150;
    localparam int RELOCK_WORDS  = 150;
    localparam int RESUME_WORDS  = 20;
    localparam int N_INJ         = 4;
    localparam int N_FLIP        = 4;
    localparam int TOTAL_WORDS   = PATTERN_WORDS + 6 * LOCK_WORDS + 3 * (N_INJ + N_FLIP)
                                 + `PRBS_LOSS_RUN + 2 + RELOCK_WORDS + RESUME_WORDS;
    localparam longint WATCHDOG_NS = longint'(TOTAL_WORDS) * `PRBS_DIV * 2 * 2 * CLK_HALF
                                   + 20000;

    logic                   emu_clk;
    logic                   emu_rst;
    prbs_mode_e             mode;
    logic                   invert;
    logic                   err_inj;
    logic                   clear;
    logic                   tx_ready;
    logic [NTI-1:0]         tx_data;
    logic                   tx_valid;
    logic [NTI-1:0]         rx_data;
    logic                   rx_valid;
    logic [`PRBS_CNT_W-1:0] words_sent;
    logic [`PRBS_CNT_W-1:0] words_checked;
    logic [`PRBS_CNT_W-1:0] bit_errors;
    logic [`PRBS_CNT_W-1:0] lock_losses;
    logic                   all_locked;

    logic [31:0]    lfsr_q = 32'h39ce0b5d;
    logic           rand_ready_en;
    logic           sent_q;
    logic [NTI-1:0] sent_word_q;
    int             tx_count;
    logic [NTI-1:0] flip_mask;
    int             flip_words;
    int             tb_errors;
    string          cur_test;

    prbs_link_emu u_prbs_link_emu (
        .emu_clk         (emu_clk),
        .emu_rst         (emu_rst),
        .mode_i          (mode),
        .invert_i        (invert),
        .err_inj_i       (err_inj),
        .clear_i         (clear),
        .tx_ready_i      (tx_ready),
        .tx_data_o       (tx_data),
        .tx_valid_o      (tx_valid),
        .rx_data_i       (rx_data),
        .rx_valid_i      (rx_valid),
        .words_sent_o    (words_sent),
        .words_checked_o (words_checked),
        .bit_errors_o    (bit_errors),
        .lock_losses_o   (lock_losses),
        .all_locked_o    (all_locked)
    );

    link_scoreboard u_link_scoreboard (
        .emu_clk         (emu_clk),
        .emu_rst         (emu_rst),
        .mode_i          (mode),
        .invert_i        (invert),
        .err_inj_i       (err_inj),
        .clear_i         (clear),
        .tx_ready_i      (tx_ready),
        .tx_data_i       (tx_data),
        .tx_valid_i      (tx_valid),
        .rx_data_i       (rx_data),
        .rx_valid_i      (rx_valid),
        .words_sent_i    (words_sent),
        .words_checked_i (words_checked),
        .bit_errors_i    (bit_errors),
        .lock_losses_i   (lock_losses),
        .all_locked_i    (all_locked)
    );

    always #CLK_HALF emu_clk = ~emu_clk;

    // Galois LFSR, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
        end
        return r;
    endfunction

    // Transfers seen at the clock edge
    always @(posedge emu_clk) begin
        if (emu_rst) begin
            sent_q   <= 1'b0;
            tx_count <= 0;
        end else begin
            sent_q      <= tx_valid & tx_ready;
            sent_word_q <= tx_data;
            if (tx_valid && tx_ready) begin
                tx_count <= tx_count + 1;
            end
        end
    end

    // Loopback with planned flips, plus random ready
    always @(negedge emu_clk) begin
        logic [NTI-1:0] flips;
        flips = '0;
        if (sent_q && flip_words > 0) begin
            flips = flip_mask;
            flip_words--;
        end
        rx_valid = sent_q;
        rx_data  = sent_word_q ^ flips;
        if (rand_ready_en) begin
            tx_ready = (rand_bits(2) != 0);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests completed");
        $display("Test failures found");
        $finish;
    end

    task automatic set_test(input string name);
        cur_test = name;
        u_link_scoreboard.set_test(name);
    endtask

    task automatic check(input string what, input longint exp, input longint act);
        if (exp !== act) begin
            tb_errors++;
            $display("mismatch %s %s: expected %0d actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic apply_reset(input prbs_mode_e m, input logic inv);
        @(negedge emu_clk);
        emu_rst = 1'b1;
        mode = m;
        invert = inv;
        repeat (4) @(negedge emu_clk);
        emu_rst = 1'b0;
    endtask

    task automatic run_words(input int n);
        int target;
        target = tx_count + n;
        rand_ready_en = 1'b1;
        while (tx_count < target) begin
            @(negedge emu_clk);
        end
    endtask

    // Stop traffic and let results reach the counters
    task automatic pause_traffic();
        rand_ready_en = 1'b0;
        tx_ready = 1'b0;
        repeat (5) @(negedge emu_clk);
    endtask

    task automatic lock_phase(input prbs_mode_e m, input logic inv);
        apply_reset(m, inv);
        set_test($sformatf("lock_%s_inv%0d", m.name(), inv));
        run_words(LOCK_WORDS);
        pause_traffic();
        check("all_locked", 1, all_locked);
        check("bit_errors", 0, bit_errors);
        check("words_checked", tx_count, words_checked);
    endtask

    task automatic error_phase();
        longint base;
        base = bit_errors;
        set_test("inject_and_flip");
        // A stalled word must be able to drain before each request
        rand_ready_en = 1'b1;
        for (int k = 0; k < N_INJ; k++) begin
            repeat (rand_bits(2)) @(negedge emu_clk);
            while (tx_valid) begin
                @(negedge emu_clk);
            end
            err_inj = 1'b1;
            @(negedge emu_clk);
            err_inj = 1'b0;
            run_words(3);
        end
        for (int k = 0; k < N_FLIP; k++) begin
            repeat (rand_bits(3)) @(negedge emu_clk);
            flip_mask = NTI'(1) << rand_bits(4);
            flip_words = 1;
            run_words(3);
        end
        pause_traffic();
        check("bit_errors", base + N_INJ + N_FLIP, bit_errors);
        check("all_locked", 1, all_locked);
    endtask

    task automatic loss_phase();
        longint base_err;
        longint base_loss;
        logic [NTI-1:0] mask;
        base_err = bit_errors;
        base_loss = lock_losses;
        set_test("lock_loss");
        mask = NTI'(rand_bits(NTI));
        if (mask == '0) begin
            mask = 1;
        end
        flip_mask = mask;
        flip_words = `PRBS_LOSS_RUN;
        run_words(`PRBS_LOSS_RUN + 2);
        pause_traffic();
        check("lock_losses", base_loss + $countones(mask), lock_losses);
        check("bit_errors", base_err + $countones(mask) * `PRBS_LOSS_RUN, bit_errors);
        check("all_locked after burst", 0, all_locked);
        run_words(RELOCK_WORDS);
        pause_traffic();
        check("all_locked after relock", 1, all_locked);
    endtask

    task automatic clear_phase();
        int base;
        set_test("clear");
        @(negedge emu_clk);
        clear = 1'b1;
        @(negedge emu_clk);
        clear = 1'b0;
        repeat (2) @(negedge emu_clk);
        check("words_sent", 0, words_sent);
        check("words_checked", 0, words_checked);
        check("bit_errors", 0, bit_errors);
        check("lock_losses", 0, lock_losses);
        base = tx_count;
        run_words(RESUME_WORDS);
        pause_traffic();
        check("words_sent resumed", tx_count - base, words_sent);
        check("words_checked resumed", tx_count - base, words_checked);
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int total;
        emu_clk = 1'b0;
        emu_rst = 1'b1;
        mode = PRBS31;
        invert = 1'b0;
        err_inj = 1'b0;
        clear = 1'b0;
        tx_ready = 1'b0;
        rx_data = '0;
        rx_valid = 1'b0;
        rand_ready_en = 1'b0;
        flip_mask = '0;
        flip_words = 0;
        tb_errors = 0;
        cur_test = "reset";

        // Pattern, seeds and back-pressure
        apply_reset(PRBS31, 1'b0);
        set_test("pattern_seed");
        run_words(PATTERN_WORDS);
        pause_traffic();
        check("words_sent", tx_count, words_sent);

        for (int m = 0; m < 3; m++) begin
            lock_phase(prbs_mode_e'(m), 1'b0);
            lock_phase(prbs_mode_e'(m), 1'b1);
        end
        error_phase();
        loss_phase();
        clear_phase();

        total = tb_errors + u_link_scoreboard.error_count + u_link_scoreboard.fail_count;
        $display("Closing counts: tb mismatches %0d, scoreboard mismatches %0d, other %0d",
                 tb_errors, u_link_scoreboard.error_count, u_link_scoreboard.fail_count);
        if (total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- testbench/link_scoreboard.sv
`timescale 1ns/1ps
`include "prbs_defines.svh"

module link_scoreboard (
    input  logic                    emu_clk,
    input  logic                    emu_rst,
    input  pattern_pkg::prbs_mode_e mode_i,
    input  logic                    invert_i,
    input  logic                    err_inj_i,
    input  logic                    clear_i,
    input  logic                    tx_ready_i,
    input  logic [`PRBS_NTI-1:0]    tx_data_i,
    input  logic                    tx_valid_i,
    input  logic [`PRBS_NTI-1:0]    rx_data_i,
    input  logic                    rx_valid_i,
    input  logic [`PRBS_CNT_W-1:0]  words_sent_i,
    input  logic [`PRBS_CNT_W-1:0]  words_checked_i,
    input  logic [`PRBS_CNT_W-1:0]  bit_errors_i,
    input  logic [`PRBS_CNT_W-1:0]  lock_losses_i,
    input  logic                    all_locked_i
);
    import pattern_pkg::*;

    localparam int NTI = `PRBS_NTI;

    int    error_count = 0;
    int    fail_count  = 0;
    string test_name   = "reset";

    // Generator and checker model state
    logic [30:0]    gen_q  [NTI];
    logic [30:0]    hist_q [NTI];
    int             run_q  [NTI];
    int             miss_q [NTI];
    logic [NTI-1:0] lock_q;
    logic [NTI-1:0] lock_d1;
    logic           inj_flag;
    logic           held_valid;
    logic [NTI-1:0] held_data;
    logic           valid_prev;
    int             gap;

    // Counter values as the DUT ports should show them, plus one result stage
    longint vis_sent, vis_checked, vis_err, vis_loss;
    int     d1_v, d1_err, d1_loss;
    logic   vis_all;

    task automatic set_test(input string name);
        test_name = name;
    endtask

    // Taps 7/6, 15/14 and 31/28 as 1-based positions
    function automatic logic next_bit(input logic [30:0] s, input prbs_mode_e m);
        logic b;
        case (m)
            PRBS7:   b = s[6] ^ s[5];
            PRBS15:  b = s[14] ^ s[13];
            default: b = s[30] ^ s[27];
        endcase
        return b;
    endfunction

    task automatic compare(input string what, input longint exp, input longint act);
        if (exp !== act) begin
            error_count++;
            $display("mismatch %s %s: expected %0h actual %0h", test_name, what, exp, act);
        end
    endtask

    always @(posedge emu_clk) begin
        logic [NTI-1:0] exp_word;
        logic           b;
        logic           p;
        int             n_err;
        int             n_loss;
        if (emu_rst) begin
            for (int i = 0; i < NTI; i++) begin
                gen_q[i]  = 31'(i + 1);
                hist_q[i] = '0;
                run_q[i]  = 0;
                miss_q[i] = 0;
            end
            lock_q = '0;
            lock_d1 = '0;
            inj_flag = 1'b0;
            held_valid = 1'b0;
            valid_prev = 1'b0;
            gap = 0;
            {vis_sent, vis_checked, vis_err, vis_loss} = '0;
            {d1_v, d1_err, d1_loss} = '0;
            vis_all = 1'b0;
        end else begin
            compare("words_sent", vis_sent, words_sent_i);
            compare("words_checked", vis_checked, words_checked_i);
            compare("bit_errors", vis_err, bit_errors_i);
            compare("lock_losses", vis_loss, lock_losses_i);
            compare("all_locked", vis_all, all_locked_i);

            ////////////////////////////////////////////////////////////
            // Handshake and pattern
            ////////////////////////////////////////////////////////////
            if (held_valid) begin
                if (!tx_valid_i) begin
                    fail_count++;
                    $display("%s: tx_valid_o dropped during a stall", test_name);
                end else begin
                    compare("stalled tx_data", held_data, tx_data_i);
                end
            end
            held_valid = tx_valid_i && !tx_ready_i;
            held_data  = tx_data_i;
            if (tx_valid_i && !valid_prev) begin
                compare("word spacing", `PRBS_DIV, gap);
            end
            valid_prev = tx_valid_i;

            if (tx_valid_i && tx_ready_i) begin
                gap = 0;
                for (int i = 0; i < NTI; i++) begin
                    b = next_bit(gen_q[i], mode_i);
                    exp_word[i] = b ^ invert_i;
                    gen_q[i] = {gen_q[i][29:0], b};
                end
                exp_word[0] = exp_word[0] ^ inj_flag;
                inj_flag = 1'b0;
                compare("tx word", exp_word, tx_data_i);
            end else if (!tx_valid_i) begin
                gap++;
            end
            // Requests only come while no word is waiting
            if (err_inj_i) begin
                inj_flag = 1'b1;
            end

            if (clear_i) begin
                {vis_sent, vis_checked, vis_err, vis_loss} = '0;
            end else begin
                vis_sent    += (tx_valid_i && tx_ready_i) ? 1 : 0;
                vis_checked += d1_v;
                vis_err     += d1_err;
                vis_loss    += d1_loss;
            end
            vis_all = &lock_d1;

            ////////////////////////////////////////////////////////////
            // Checker lanes
            ////////////////////////////////////////////////////////////
            n_err = 0;
            n_loss = 0;
            if (rx_valid_i) begin
                for (int i = 0; i < NTI; i++) begin
                    b = rx_data_i[i] ^ invert_i;
                    p = next_bit(hist_q[i], mode_i);
                    if (!lock_q[i]) begin
                        hist_q[i] = {hist_q[i][29:0], b};
                        miss_q[i] = 0;
                        if (b != p) begin
                            run_q[i] = 0;
                        end else if (run_q[i] == `PRBS_LOCK_RUN - 1) begin
                            lock_q[i] = 1'b1;
                            run_q[i] = 0;
                        end else begin
                            run_q[i]++;
                        end
                    end else begin
                        // Locked lanes run on their own prediction
                        hist_q[i] = {hist_q[i][29:0], p};
                        if (b == p) begin
                            miss_q[i] = 0;
                        end else begin
                            n_err++;
                            if (miss_q[i] == `PRBS_LOSS_RUN - 1) begin
                                lock_q[i] = 1'b0;
                                miss_q[i] = 0;
                                n_loss++;
                            end else begin
                                miss_q[i]++;
                            end
                        end
                    end
                end
            end
            d1_v = rx_valid_i;
            d1_err = n_err;
            d1_loss = n_loss;
            lock_d1 = lock_q;
        end
    end

endmodule

//--- src/prbs_link_emu.sv
`timescale 1ns/1ps
`include "prbs_defines.svh"

module prbs_link_emu (
    input  logic                    emu_clk,
    input  logic                    emu_rst,
    input  pattern_pkg::prbs_mode_e mode_i,
    input  logic                    invert_i,
    input  logic                    err_inj_i,
    input  logic                    clear_i,
    input  logic                    tx_ready_i,
    output logic [`PRBS_NTI-1:0]    tx_data_o,
    output logic                    tx_valid_o,
    input  logic [`PRBS_NTI-1:0]    rx_data_i,
    input  logic                    rx_valid_i,
    output logic [`PRBS_CNT_W-1:0]  words_sent_o,
    output logic [`PRBS_CNT_W-1:0]  words_checked_o,
    output logic [`PRBS_CNT_W-1:0]  bit_errors_o,
    output logic [`PRBS_CNT_W-1:0]  lock_losses_o,
    output logic                    all_locked_o
);
    import monitor_pkg::*;

    logic        word_sent;
    link_stats_t stats;

    chk_result_if u_chk_result_if ();

    // Pattern source
    prbs_lane_bank u_prbs_lane_bank (
        .emu_clk     (emu_clk),
        .emu_rst     (emu_rst),
        .mode_i      (mode_i),
        .invert_i    (invert_i),
        .err_inj_i   (err_inj_i),
        .tx_ready_i  (tx_ready_i),
        .tx_data_o   (tx_data_o),
        .tx_valid_o  (tx_valid_o),
        .word_sent_o (word_sent)
    );

    // Receive side checker
    prbs_lane_checker u_prbs_lane_checker (
        .emu_clk    (emu_clk),
        .emu_rst    (emu_rst),
        .mode_i     (mode_i),
        .invert_i   (invert_i),
        .rx_data_i  (rx_data_i),
        .rx_valid_i (rx_valid_i),
        .res        (u_chk_result_if.src)
    );

    link_stat_unit u_link_stat_unit (
        .emu_clk      (emu_clk),
        .emu_rst      (emu_rst),
        .clear_i      (clear_i),
        .word_sent_i  (word_sent),
        .res          (u_chk_result_if.dst),
        .stats_o      (stats),
        .all_locked_o (all_locked_o)
    );

    // Statistics record onto plain ports
    assign words_sent_o    = stats.words_sent;
    assign words_checked_o = stats.words_checked;
    assign bit_errors_o    = stats.bit_errors;
    assign lock_losses_o   = stats.lock_losses;

endmodule

//--- src/link_stat_unit.sv
`timescale 1ns/1ps
`include "prbs_defines.svh"

module link_stat_unit (
    input  logic                     emu_clk,
    input  logic                     emu_rst,
    input  logic                     clear_i,
    input  logic                     word_sent_i,
    chk_result_if.dst                res,
    output monitor_pkg::link_stats_t stats_o,
    output logic                     all_locked_o
);
    import pattern_pkg::*;
    import monitor_pkg::*;

    localparam int POP_W = $clog2(`PRBS_NTI + 1);

    logic [POP_W-1:0] err_pop;
    logic [POP_W-1:0] loss_pop;

    // Number of set lanes in a mask
    function automatic logic [POP_W-1:0] popcount(input lane_word_t m);
        logic [POP_W-1:0] n;
        n = '0;
        for (int i = 0; i < `PRBS_NTI; i++) begin
            n = n + POP_W'(m[i]);
        end
        return n;
    endfunction

    assign err_pop  = popcount(res.err_mask);
    assign loss_pop = popcount(res.loss_mask);

    ////////////////////////////////////////////////////////////
    // Counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge emu_clk) begin
        if (emu_rst || clear_i) begin
            stats_o <= '0;
        end else begin
            if (word_sent_i) begin
                stats_o.words_sent <= stats_o.words_sent + 1'b1;
            end
            if (res.res_valid) begin
                stats_o.words_checked <= stats_o.words_checked + 1'b1;
                stats_o.bit_errors    <= stats_o.bit_errors + stat_cnt_t'(err_pop);
                stats_o.lock_losses   <= stats_o.lock_losses + stat_cnt_t'(loss_pop);
            end
        end
    end

    // Lock flag is not a counter and ignores clear
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            all_locked_o <= 1'b0;
        end else begin
            all_locked_o <= &res.lock_mask;
        end
    end

endmodule

//--- src/prbs_lane_checker.sv
`timescale 1ns/1ps
`include "prbs_defines.svh"

module prbs_lane_checker (
    input  logic                    emu_clk,
    input  logic                    emu_rst,
    input  pattern_pkg::prbs_mode_e mode_i,
    input  logic                    invert_i,
    input  pattern_pkg::lane_word_t rx_data_i,
    input  logic                    rx_valid_i,
    chk_result_if.src               res
);
    import pattern_pkg::*;
    import monitor_pkg::*;

    localparam int RUN_W  = $clog2(`PRBS_LOCK_RUN + 1);
    localparam int MISS_W = $clog2(`PRBS_LOSS_RUN + 1);

    chk_state_e        state_q [`PRBS_NTI];
    prbs_state_t       hist_q  [`PRBS_NTI];
    logic [RUN_W-1:0]  run_q   [`PRBS_NTI];
    logic [MISS_W-1:0] miss_q  [`PRBS_NTI];

    lane_word_t rx_bits;
    lane_word_t pred_bits;
    lane_word_t hit_bits;
    lane_word_t lock_bits;
    lane_word_t err_q;
    lane_word_t loss_q;
    logic       res_valid_q;

    // Undo the inversion before comparing
    assign rx_bits  = rx_data_i ^ {`PRBS_NTI{invert_i}};
    assign hit_bits = ~(rx_bits ^ pred_bits);

    always_comb begin
        for (int i = 0; i < `PRBS_NTI; i++) begin
            pred_bits[i] = prbs_fb(hist_q[i], mode_i);
            lock_bits[i] = (state_q[i] == LOCKED);
        end
    end

    ////////////////////////////////////////////////////////////
    // Per-lane lock FSMs
    ////////////////////////////////////////////////////////////

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            for (int i = 0; i < `PRBS_NTI; i++) begin
                state_q[i] <= HUNT;
                hist_q[i]  <= '0;
                run_q[i]   <= '0;
                miss_q[i]  <= '0;
            end
            err_q       <= '0;
            loss_q      <= '0;
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= rx_valid_i;
            err_q       <= '0;
            loss_q      <= '0;
            if (rx_valid_i) begin
                for (int i = 0; i < `PRBS_NTI; i++) begin
                    if (state_q[i] == HUNT) begin
                        // History follows the line while hunting
                        hist_q[i] <= prbs_shift(hist_q[i], rx_bits[i]);
                        miss_q[i] <= '0;
                        if (!hit_bits[i]) begin
                            run_q[i] <= '0;
                        end else if (run_q[i] == RUN_W'(`PRBS_LOCK_RUN - 1)) begin
                            state_q[i] <= LOCKED;
                            run_q[i]   <= '0;
                        end else begin
                            run_q[i] <= run_q[i] + 1'b1;
                        end
                    end else begin
                        // Free running once locked, so a flipped bit
                        // is counted once and not fed back into the taps
                        hist_q[i] <= prbs_shift(hist_q[i], pred_bits[i]);
                        if (hit_bits[i]) begin
                            miss_q[i] <= '0;
                        end else begin
                            err_q[i] <= 1'b1;
                            if (miss_q[i] == MISS_W'(`PRBS_LOSS_RUN - 1)) begin
                                state_q[i] <= HUNT;
                                miss_q[i]  <= '0;
                                loss_q[i]  <= 1'b1;
                            end else begin
                                miss_q[i] <= miss_q[i] + 1'b1;
                            end
                        end
                    end
                end
            end
        end
    end

    // Results one cycle after the word
    assign res.res_valid = res_valid_q;
    assign res.err_mask  = err_q;
    assign res.loss_mask = loss_q;
    assign res.lock_mask = lock_bits;

endmodule

//--- src/prbs_lane_bank.sv
`timescale 1ns/1ps
`include "prbs_defines.svh"

module prbs_lane_bank (
    input  logic                    emu_clk,
    input  logic                    emu_rst,
    input  pattern_pkg::prbs_mode_e mode_i,
    input  logic                    invert_i,
    input  logic                    err_inj_i,
    input  logic                    tx_ready_i,
    output pattern_pkg::lane_word_t tx_data_o,
    output logic                    tx_valid_o,
    output logic                    word_sent_o
);
    import pattern_pkg::*;

    localparam int DIV_W = $clog2(`PRBS_DIV + 1);

    prbs_state_t      lane_q [`PRBS_NTI];
    lane_word_t       fb_bits;
    logic [DIV_W-1:0] step_q;
    logic             step_done;
    logic             inj_pend_q;
    logic             inj_now;

    // Next bit of every lane
    always_comb begin
        for (int i = 0; i < `PRBS_NTI; i++) begin
            fb_bits[i] = prbs_fb(lane_q[i], mode_i);
        end
    end

    // Counter only runs while no word is waiting
    assign step_done   = !tx_valid_o && (step_q == DIV_W'(`PRBS_DIV - 1));
    assign word_sent_o = tx_valid_o & tx_ready_i;

    // A request in the producing cycle still lands on this word
    assign inj_now = inj_pend_q | err_inj_i;

    ////////////////////////////////////////////////////////////
    // Step divider and output handshake
    ////////////////////////////////////////////////////////////

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            step_q     <= '0;
            tx_valid_o <= 1'b0;
        end else if (!tx_valid_o) begin
            if (step_done) begin
                step_q     <= '0;
                tx_valid_o <= 1'b1;
            end else begin
                step_q <= step_q + 1'b1;
            end
        end else if (word_sent_o) begin
            tx_valid_o <= 1'b0;
        end
    end

    // Injection request held until a word is produced
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            inj_pend_q <= 1'b0;
        end else if (step_done) begin
            inj_pend_q <= 1'b0;
        end else if (err_inj_i) begin
            inj_pend_q <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Lane registers and output word
    ////////////////////////////////////////////////////////////

    // Seeds are lane index plus one
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            for (int i = 0; i < `PRBS_NTI; i++) begin
                lane_q[i] <= prbs_state_t'(i + 1);
            end
        end else if (step_done) begin
            for (int i = 0; i < `PRBS_NTI; i++) begin
                lane_q[i] <= prbs_shift(lane_q[i], fb_bits[i]);
            end
        end
    end

    // Inversion and lane 0 flip touch the output only
    always_ff @(posedge emu_clk) begin
        if (step_done) begin
            tx_data_o <= fb_bits ^ {`PRBS_NTI{invert_i}} ^ lane_word_t'(inj_now);
        end
    end

endmodule

//--- src/chk_result_if.sv
`timescale 1ns/1ps

interface chk_result_if;
    import pattern_pkg::*;

    // One result per checked word
    logic       res_valid;
    lane_word_t err_mask;
    lane_word_t lock_mask;
    lane_word_t loss_mask;

    // Checker side
    modport src (
        output res_valid, err_mask, lock_mask, loss_mask
    );

    // Statistics side
    modport dst (
        input res_valid, err_mask, lock_mask, loss_mask
    );

endinterface

//--- src/monitor_pkg.sv
`include "prbs_defines.svh"

package monitor_pkg;

    // Lane checker states
    typedef enum logic {
        HUNT   = 1'b0,
        LOCKED = 1'b1
    } chk_state_e;

    // One statistics counter
    typedef logic [`PRBS_CNT_W-1:0] stat_cnt_t;

    ////////////////////////////////////////////////////////////
    // Link statistics record
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        // Words accepted on the generator output
        stat_cnt_t words_sent;
        // Words taken by the checker
        stat_cnt_t words_checked;
        // Mispredicted bits in locked lanes
        stat_cnt_t bit_errors;
        // Lock to hunt transitions summed over lanes
        stat_cnt_t lock_losses;
    } link_stats_t;

endpackage

//--- src/pattern_pkg.sv
`include "prbs_defines.svh"

package pattern_pkg;

    // Polynomial select
    typedef enum logic [1:0] {
        PRBS7  = 2'd0,
        PRBS15 = 2'd1,
        PRBS31 = 2'd2
    } prbs_mode_e;

    // Per-lane shift register, the short modes live in the low bits
    typedef logic [30:0] prbs_state_t;

    // One bit per interleaved lane
    typedef logic [`PRBS_NTI-1:0] lane_word_t;

    // Feedback bit of a register for the selected polynomial
    // Taps are 1-based, so tap n is bit n-1
    function automatic logic prbs_fb(input prbs_state_t s, input prbs_mode_e m);
        logic fb;
        case (m)
            PRBS7:   fb = s[6] ^ s[5];
            PRBS15:  fb = s[14] ^ s[13];
            default: fb = s[30] ^ s[27];
        endcase
        return fb;
    endfunction

    // Next register value once the feedback bit is known
    function automatic prbs_state_t prbs_shift(input prbs_state_t s, input logic b);
        return {s[29:0], b};
    endfunction

endpackage

//--- include/prbs_defines.svh
`ifndef PRBS_DEFINES_SVH
`define PRBS_DEFINES_SVH

// Number of interleaved slices, one PRBS lane per slice
`define PRBS_NTI 16

// Emulator clocks per pattern step
`define PRBS_DIV 6

// Consecutive good predictions before a lane counts as locked
`define PRBS_LOCK_RUN 40

// Consecutive misses that send a locked lane back to hunting
`define PRBS_LOSS_RUN 8

// Statistics counter width
`define PRBS_CNT_W 32

`endif
